//--- hdl/rv_mem_pkg.sv
package rv_mem_pkg;

    // ********************************************************************
    // Datapath geometry
    // ********************************************************************
    localparam int XLEN      = 32;  // Data and address width
    localparam int REG_IDX_W = 5;   // Register index, x0..x31
    localparam int DMEM_AW   = 10;  // Word address bits, 1024 words = 4 KiB

    // ********************************************************************
    // Memory operation codes, EXE -> MEM
    // ********************************************************************
    localparam int DMEM_TYPE_W = 4;

    localparam logic [DMEM_TYPE_W-1:0] DMEM_NO  = 4'd0;  // No access
    localparam logic [DMEM_TYPE_W-1:0] DMEM_LB  = 4'd1;
    localparam logic [DMEM_TYPE_W-1:0] DMEM_LH  = 4'd2;
    localparam logic [DMEM_TYPE_W-1:0] DMEM_LW  = 4'd3;
    localparam logic [DMEM_TYPE_W-1:0] DMEM_LBU = 4'd4;
    localparam logic [DMEM_TYPE_W-1:0] DMEM_LHU = 4'd5;
    localparam logic [DMEM_TYPE_W-1:0] DMEM_SB  = 4'd6;
    localparam logic [DMEM_TYPE_W-1:0] DMEM_SH  = 4'd7;
    localparam logic [DMEM_TYPE_W-1:0] DMEM_SW  = 4'd8;

    // ********************************************************************
    // Write-back result sources
    // ********************************************************************
    localparam int RESULT_SRC_W = 4;

    // RES_ALU is zero so a cleared pipeline register selects the ALU path
    localparam logic [RESULT_SRC_W-1:0] RES_ALU = 4'd0;
    localparam logic [RESULT_SRC_W-1:0] RES_MEM = 4'd1;  // Load data
    localparam logic [RESULT_SRC_W-1:0] RES_IMM = 4'd2;  // lui
    localparam logic [RESULT_SRC_W-1:0] RES_PC4 = 4'd3;  // jal / jalr link

endpackage

//--- hdl/store_align.sv
`timescale 1ns/1ps

// Places store data on the right byte lanes and builds the SRAM mask
module store_align import rv_mem_pkg::*; (
    input  logic [DMEM_TYPE_W-1:0] dmem_type_i,   // Memory op from EXE
    input  logic [1:0]             byte_off_i,    // Address bits 1:0
    input  logic [XLEN-1:0]        store_data_i,  // rs2 value
    output logic [XLEN-1:0]        wdata_o,       // Lane-placed write data
    output logic [3:0]             byte_en_o      // One bit per byte lane
);

    always_comb begin
        // Defaults, also used for loads and NO
        wdata_o   = '0;
        byte_en_o = 4'b0000;

        case (dmem_type_i)
            DMEM_SW: begin
                wdata_o   = store_data_i;  // Whole word
                byte_en_o = 4'b1111;
            end

            DMEM_SB: begin
                // Low byte goes to the lane picked by the offset
                case (byte_off_i)
                    2'b00: begin
                        wdata_o   = {24'h0, store_data_i[7:0]};
                        byte_en_o = 4'b0001;
                    end
                    2'b01: begin
                        wdata_o   = {16'h0, store_data_i[7:0], 8'h0};
                        byte_en_o = 4'b0010;
                    end
                    2'b10: begin
                        wdata_o   = {8'h0, store_data_i[7:0], 16'h0};
                        byte_en_o = 4'b0100;
                    end
                    default: begin
                        wdata_o   = {store_data_i[7:0], 24'h0};
                        byte_en_o = 4'b1000;
                    end
                endcase
            end

            DMEM_SH: begin
                // Offset 00 is the low half, anything else the high half
                if (byte_off_i == 2'b00) begin
                    wdata_o   = {16'h0, store_data_i[15:0]};
                    byte_en_o = 4'b0011;
                end else begin
                    wdata_o   = {store_data_i[15:0], 16'h0};
                    byte_en_o = 4'b1100;
                end
            end

            default: begin
                wdata_o   = '0;
                byte_en_o = 4'b0000;
            end
        endcase
    end

endmodule

//--- hdl/dmem_sram.sv
`timescale 1ns/1ps

// Single-port data SRAM, one word per address, byte-masked writes
module dmem_sram import rv_mem_pkg::*; (
    input  logic               clk,
    input  logic               ceb_i,    // Chip enable, active low
    input  logic               web_i,    // Write enable, active low
    input  logic [DMEM_AW-1:0] addr_i,   // Word address
    input  logic [3:0]         mask_i,   // Byte lanes to write
    input  logic [XLEN-1:0]    wdata_i,
    output logic [XLEN-1:0]    rdata_o   // Valid one cycle after the read edge
);

    localparam int DEPTH = 1 << DMEM_AW;

    // ********************************************************************
    // Storage array
    // ********************************************************************
    logic [XLEN-1:0] mem [DEPTH];

    // Write port, only masked lanes change
    always_ff @(posedge clk) begin
        if (!ceb_i && !web_i) begin
            for (int b = 0; b < 4; b++) begin
                if (mask_i[b])
                    mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
            end
        end
    end

    // Registered read port
    always_ff @(posedge clk) begin
        if (!ceb_i && web_i)
            rdata_o <= mem[addr_i];  // Holds last word otherwise
    end

endmodule

//--- hdl/load_extract.sv
`timescale 1ns/1ps

// Lines the load type up with the SRAM output, then picks and extends the lane
module load_extract import rv_mem_pkg::*; (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic [DMEM_TYPE_W-1:0] dmem_type_i,   // Op in the access cycle
    input  logic [1:0]             byte_off_i,    // Address bits 1:0
    input  logic [XLEN-1:0]        sram_rdata_i,  // Word from the SRAM
    output logic [XLEN-1:0]        load_data_o    // Extended load result
);

    logic [DMEM_TYPE_W-1:0] mem_op_q;    // Type, one cycle late
    logic [1:0]             byte_off_q;  // Offset, one cycle late
    logic [7:0]             sel_byte;
    logic [15:0]            sel_half;

    // ********************************************************************
    // Align control with the SRAM read latency
    // ********************************************************************
    always_ff @(posedge clk) begin
        if (!resetn)
            mem_op_q <= DMEM_NO;
        else
            mem_op_q <= dmem_type_i;
    end

    always_ff @(posedge clk) begin
        byte_off_q <= byte_off_i;
    end

    // ********************************************************************
    // Lane select
    // ********************************************************************
    always_comb begin
        case (byte_off_q)
            2'b00:   sel_byte = sram_rdata_i[7:0];
            2'b01:   sel_byte = sram_rdata_i[15:8];
            2'b10:   sel_byte = sram_rdata_i[23:16];
            default: sel_byte = sram_rdata_i[31:24];
        endcase
    end

    // Only bit 1 picks the half
    assign sel_half = byte_off_q[1] ? sram_rdata_i[31:16] : sram_rdata_i[15:0];

    // Sign or zero extension by type
    always_comb begin
        case (mem_op_q)
            DMEM_LB:  load_data_o = {{24{sel_byte[7]}}, sel_byte};
            DMEM_LBU: load_data_o = {24'h0, sel_byte};
            DMEM_LH:  load_data_o = {{16{sel_half[15]}}, sel_half};
            DMEM_LHU: load_data_o = {16'h0, sel_half};
            default:  load_data_o = sram_rdata_i;  // LW and non-loads
        endcase
    end

endmodule

//--- hdl/mem_stage.sv
`timescale 1ns/1ps

// MEM stage: data memory access plus the EXE->MEM write-back register
module mem_stage import rv_mem_pkg::*; (
    input  logic                    clk,
    input  logic                    resetn,
    // From EXE
    input  logic [XLEN-1:0]         alu_result_i,    // Also the memory address
    input  logic [DMEM_TYPE_W-1:0]  dmem_type_i,
    input  logic [XLEN-1:0]         store_data_i,
    input  logic [XLEN-1:0]         ext_imm_i,
    input  logic [XLEN-1:0]         pc_plus4_i,
    input  logic                    reg_write_en_i,
    input  logic [REG_IDX_W-1:0]    rd_idx_i,
    input  logic [RESULT_SRC_W-1:0] result_src_i,
    // To write-back
    output logic [XLEN-1:0]         mem_rdata_o,     // Extended load data
    output logic [XLEN-1:0]         alu_result_o,
    output logic [XLEN-1:0]         ext_imm_o,
    output logic [XLEN-1:0]         pc_plus4_o,
    output logic                    reg_write_en_o,
    output logic [REG_IDX_W-1:0]    rd_idx_o,
    output logic [RESULT_SRC_W-1:0] result_src_o
);

    logic [DMEM_AW-1:0] dmem_addr;
    logic [1:0]         byte_off;
    logic               ceb;
    logic               web;
    logic               is_store;
    logic [XLEN-1:0]    dmem_wdata;
    logic [3:0]         byte_en;
    logic [XLEN-1:0]    sram_rdata;

    // ********************************************************************
    // SRAM control decode
    // ********************************************************************
    assign dmem_addr = alu_result_i[DMEM_AW+1:2];  // Word index, bits 11:2
    assign byte_off  = alu_result_i[1:0];

    assign is_store = (dmem_type_i == DMEM_SB) ||
                      (dmem_type_i == DMEM_SH) ||
                      (dmem_type_i == DMEM_SW);

    assign ceb = (dmem_type_i == DMEM_NO);  // Any real op selects the chip
    assign web = !is_store;                 // Low only for stores

    // Store path
    store_align u_store_align (
        .dmem_type_i  (dmem_type_i),
        .byte_off_i   (byte_off),
        .store_data_i (store_data_i),
        .wdata_o      (dmem_wdata),
        .byte_en_o    (byte_en)
    );

    dmem_sram u_dmem_sram (
        .clk     (clk),
        .ceb_i   (ceb),
        .web_i   (web),
        .addr_i  (dmem_addr),
        .mask_i  (byte_en),
        .wdata_i (dmem_wdata),
        .rdata_o (sram_rdata)
    );

    // Load path, control registered inside to match SRAM latency
    load_extract u_load_extract (
        .clk          (clk),
        .resetn       (resetn),
        .dmem_type_i  (dmem_type_i),
        .byte_off_i   (byte_off),
        .sram_rdata_i (sram_rdata),
        .load_data_o  (mem_rdata_o)
    );

    // ********************************************************************
    // Pipeline register toward write-back
    // ********************************************************************
    always_ff @(posedge clk) begin
        if (!resetn) begin
            alu_result_o   <= '0;
            ext_imm_o      <= '0;
            pc_plus4_o     <= '0;
            reg_write_en_o <= 1'b0;   // No spurious RF write out of reset
            rd_idx_o       <= '0;
            result_src_o   <= RES_ALU;
        end else begin
            alu_result_o   <= alu_result_i;
            ext_imm_o      <= ext_imm_i;
            pc_plus4_o     <= pc_plus4_i;
            reg_write_en_o <= reg_write_en_i;
            rd_idx_o       <= rd_idx_i;
            result_src_o   <= result_src_i;
        end
    end

endmodule

//--- hdl/wb_select.sv
`timescale 1ns/1ps

// Picks the write-back value and drives the register file write port
module wb_select import rv_mem_pkg::*; (
    input  logic [RESULT_SRC_W-1:0] result_src_i,
    input  logic [XLEN-1:0]         alu_result_i,
    input  logic [XLEN-1:0]         mem_rdata_i,
    input  logic [XLEN-1:0]         ext_imm_i,
    input  logic [XLEN-1:0]         pc_plus4_i,
    input  logic                    reg_write_en_i,
    input  logic [REG_IDX_W-1:0]    rd_idx_i,
    output logic                    rf_we_o,
    output logic [REG_IDX_W-1:0]    rf_waddr_o,
    output logic [XLEN-1:0]         rf_wdata_o
);

    // Result mux
    always_comb begin
        case (result_src_i)
            RES_MEM: rf_wdata_o = mem_rdata_i;
            RES_IMM: rf_wdata_o = ext_imm_i;
            RES_PC4: rf_wdata_o = pc_plus4_i;
            default: rf_wdata_o = alu_result_i;  // RES_ALU and unknown codes
        endcase
    end

    // x0 is hardwired, never write it
    assign rf_we_o    = reg_write_en_i && (rd_idx_i != '0);
    assign rf_waddr_o = rd_idx_i;

endmodule

//--- hdl/rv_mem_top.sv
`timescale 1ns/1ps

// MEM stage followed by write-back select, one cycle EXE in to RF port out
module rv_mem_top import rv_mem_pkg::*; (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic [XLEN-1:0]         alu_result_i,
    input  logic [DMEM_TYPE_W-1:0]  dmem_type_i,
    input  logic [XLEN-1:0]         store_data_i,
    input  logic [XLEN-1:0]         ext_imm_i,
    input  logic [XLEN-1:0]         pc_plus4_i,
    input  logic                    reg_write_en_i,
    input  logic [REG_IDX_W-1:0]    rd_idx_i,
    input  logic [RESULT_SRC_W-1:0] result_src_i,
    output logic                    rf_we_o,
    output logic [REG_IDX_W-1:0]    rf_waddr_o,
    output logic [XLEN-1:0]         rf_wdata_o
);

    // MEM -> WB fields
    logic [XLEN-1:0]         m_mem_rdata;
    logic [XLEN-1:0]         m_alu_result;
    logic [XLEN-1:0]         m_ext_imm;
    logic [XLEN-1:0]         m_pc_plus4;
    logic                    m_reg_write_en;
    logic [REG_IDX_W-1:0]    m_rd_idx;
    logic [RESULT_SRC_W-1:0] m_result_src;

    mem_stage u_mem_stage (
        .clk            (clk),
        .resetn         (resetn),
        .alu_result_i   (alu_result_i),
        .dmem_type_i    (dmem_type_i),
        .store_data_i   (store_data_i),
        .ext_imm_i      (ext_imm_i),
        .pc_plus4_i     (pc_plus4_i),
        .reg_write_en_i (reg_write_en_i),
        .rd_idx_i       (rd_idx_i),
        .result_src_i   (result_src_i),
        .mem_rdata_o    (m_mem_rdata),
        .alu_result_o   (m_alu_result),
        .ext_imm_o      (m_ext_imm),
        .pc_plus4_o     (m_pc_plus4),
        .reg_write_en_o (m_reg_write_en),
        .rd_idx_o       (m_rd_idx),
        .result_src_o   (m_result_src)
    );

    wb_select u_wb_select (
        .result_src_i   (m_result_src),
        .alu_result_i   (m_alu_result),
        .mem_rdata_i    (m_mem_rdata),
        .ext_imm_i      (m_ext_imm),
        .pc_plus4_i     (m_pc_plus4),
        .reg_write_en_i (m_reg_write_en),
        .rd_idx_i       (m_rd_idx),
        .rf_we_o        (rf_we_o),
        .rf_waddr_o     (rf_waddr_o),
        .rf_wdata_o     (rf_wdata_o)
    );

endmodule

//--- tb/rv_mem_tb.sv
`timescale 1ns/1ps

module rv_mem_tb import rv_mem_pkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int N_IDLE  = 8;
    localparam int N_FILL  = 1 << DMEM_AW;  // One SW per word
    localparam int N_WORD  = 64;            // 16 SW, 16 LW, 16 SW/LW pairs
    localparam int N_LANE  = 64;            // 4 rounds x 4 offsets x 4
    localparam int N_EXT   = 128;           // 4 rounds x 4 offsets x 4 loads x 2
    localparam int N_SRC   = 64;
    localparam int N_RAND  = 2000;
    localparam int N_FLUSH = 4;
    localparam int N_TOTAL = N_IDLE + N_FILL + N_WORD + N_LANE + N_EXT + N_SRC + N_RAND
                           + N_FLUSH;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_TOTAL + 100;

    logic                    clk = 1'b0;
    logic                    resetn;
    logic [XLEN-1:0]         alu_result_i;
    logic [DMEM_TYPE_W-1:0]  dmem_type_i;
    logic [XLEN-1:0]         store_data_i;
    logic [XLEN-1:0]         ext_imm_i;
    logic [XLEN-1:0]         pc_plus4_i;
    logic                    reg_write_en_i;
    logic [REG_IDX_W-1:0]    rd_idx_i;
    logic [RESULT_SRC_W-1:0] result_src_i;
    logic                    rf_we_o;
    logic [REG_IDX_W-1:0]    rf_waddr_o;
    logic [XLEN-1:0]         rf_wdata_o;

    integer seed = 32'hbb5b_30b8;
    logic [XLEN-1:0] shadow [1 << DMEM_AW];  // Reference copy of the data SRAM

    logic [DMEM_TYPE_W-1:0] all_types [9] = '{DMEM_NO, DMEM_LB, DMEM_LH, DMEM_LW, DMEM_LBU,
                                              DMEM_LHU, DMEM_SB, DMEM_SH, DMEM_SW};
    logic [DMEM_TYPE_W-1:0] ld_types [4]  = '{DMEM_LB, DMEM_LBU, DMEM_LH, DMEM_LHU};

    // Expected write-back values, stamped with the negedge count at issue
    logic                 exp_we_q    [$];
    logic [REG_IDX_W-1:0] exp_waddr_q [$];
    logic [XLEN-1:0]      exp_wdata_q [$];
    int unsigned          exp_stamp_q [$];
    int unsigned          neg_cnt     = 0;

    rv_mem_top dut (
        .clk            (clk),
        .resetn         (resetn),
        .alu_result_i   (alu_result_i),
        .dmem_type_i    (dmem_type_i),
        .store_data_i   (store_data_i),
        .ext_imm_i      (ext_imm_i),
        .pc_plus4_i     (pc_plus4_i),
        .reg_write_en_i (reg_write_en_i),
        .rd_idx_i       (rd_idx_i),
        .result_src_i   (result_src_i),
        .rf_we_o        (rf_we_o),
        .rf_waddr_o     (rf_waddr_o),
        .rf_wdata_o     (rf_wdata_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ********************************************************************
    // Reference model
    // ********************************************************************
    function automatic logic [XLEN-1:0] expected_load(input logic [DMEM_TYPE_W-1:0] mtype,
                                                      input logic [XLEN-1:0] addr);
        logic [XLEN-1:0] word;
        logic [7:0]      lane_b;
        logic [15:0]     lane_h;
        word = shadow[addr[DMEM_AW+1:2]];
        case (addr[1:0])
            2'd0:    lane_b = word[7:0];
            2'd1:    lane_b = word[15:8];
            2'd2:    lane_b = word[23:16];
            default: lane_b = word[31:24];
        endcase
        lane_h = addr[1] ? word[31:16] : word[15:0];  // Half picked by bit 1 only
        case (mtype)
            DMEM_LB:  return {{24{lane_b[7]}}, lane_b};
            DMEM_LBU: return {24'h0, lane_b};
            DMEM_LH:  return {{16{lane_h[15]}}, lane_h};
            DMEM_LHU: return {16'h0, lane_h};
            default:  return word;  // LW
        endcase
    endfunction

    task automatic shadow_store(input logic [DMEM_TYPE_W-1:0] mtype,
                                input logic [XLEN-1:0] addr, input logic [XLEN-1:0] sdata);
        logic [XLEN-1:0] word;
        word = shadow[addr[DMEM_AW+1:2]];
        case (mtype)
            DMEM_SW: word = sdata;
            DMEM_SB: word[8*addr[1:0] +: 8] = sdata[7:0];
            DMEM_SH: begin
                if (addr[1:0] == 2'b00)
                    word[15:0] = sdata[15:0];
                else
                    word[31:16] = sdata[15:0];  // Any nonzero offset means upper half
            end
            default: ;  // Loads and NO leave memory alone
        endcase
        shadow[addr[DMEM_AW+1:2]] = word;
    endtask

    // Drives one instruction at the next rising edge and queues its result
    task automatic issue_instr(input logic [DMEM_TYPE_W-1:0] mtype,
                               input logic [XLEN-1:0] addr, input logic [XLEN-1:0] sdata,
                               input logic [RESULT_SRC_W-1:0] src, input logic wen,
                               input logic [REG_IDX_W-1:0] rd);
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] pc4;
        logic [XLEN-1:0] wb;
        imm = $random(seed);
        pc4 = $random(seed);
        @(posedge clk);
        alu_result_i   <= addr;
        dmem_type_i    <= mtype;
        store_data_i   <= sdata;
        ext_imm_i      <= imm;
        pc_plus4_i     <= pc4;
        reg_write_en_i <= wen;
        rd_idx_i       <= rd;
        result_src_i   <= src;
        case (src)
            RES_MEM: wb = expected_load(mtype, addr);  // Before any store this cycle
            RES_IMM: wb = imm;
            RES_PC4: wb = pc4;
            default: wb = addr;                        // ALU and unknown codes
        endcase
        shadow_store(mtype, addr, sdata);
        exp_we_q.push_back(wen && (rd != '0));        // x0 never written
        exp_waddr_q.push_back(rd);
        exp_wdata_q.push_back(wb);
        exp_stamp_q.push_back(neg_cnt);
    endtask

    task automatic report_mismatch(input string name, input logic [XLEN-1:0] expv,
                                   input logic [XLEN-1:0] gotv);
        $display("CHECK FAILED: %s expected 0x%h actual 0x%h", name, expv, gotv);
        $display("TEST FAIL");
        $fatal(1, "write-back mismatch");
    endtask

    // ********************************************************************
    // Checker, one cycle after the capturing edge
    // ********************************************************************
    always @(negedge clk) begin
        neg_cnt = neg_cnt + 1;
        if (exp_stamp_q.size() != 0 && neg_cnt >= exp_stamp_q[0] + 2) begin
            assert (rf_we_o === exp_we_q[0])
                else report_mismatch("rf_we_o", exp_we_q[0], rf_we_o);
            assert (rf_waddr_o === exp_waddr_q[0])
                else report_mismatch("rf_waddr_o", exp_waddr_q[0], rf_waddr_o);
            assert (rf_wdata_o === exp_wdata_q[0])
                else report_mismatch("rf_wdata_o", exp_wdata_q[0], rf_wdata_o);
            exp_we_q.delete(0);
            exp_waddr_q.delete(0);
            exp_wdata_q.delete(0);
            exp_stamp_q.delete(0);
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: run hung, not finished after %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $fatal(1, "watchdog timeout");
    end

    // ********************************************************************
    // Stimulus
    // ********************************************************************
    initial begin : main
        logic [XLEN-1:0]         a;
        logic [XLEN-1:0]         d;
        logic [DMEM_TYPE_W-1:0]  t;
        logic [RESULT_SRC_W-1:0] s;
        logic [REG_IDX_W-1:0]    rd;
        logic [XLEN-1:0]         saved [$];
        resetn         = 1'b0;
        alu_result_i   = '0;
        dmem_type_i    = DMEM_NO;
        store_data_i   = '0;
        ext_imm_i      = '0;
        pc_plus4_i     = '0;
        reg_write_en_i = 1'b0;
        rd_idx_i       = '0;
        result_src_i   = RES_ALU;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;

        for (int i = 0; i < N_IDLE; i++)  // Idle, no RF write
            issue_instr(DMEM_NO, $random(seed), '0, RES_ALU, 1'b0, $random(seed));
        for (int i = 0; i < N_FILL; i++) begin  // Whole SRAM, pattern from word index
            d = {i[9:0], 6'h1d, ~i[9:0], 6'h32};
            issue_instr(DMEM_SW, i << 2, d, RES_ALU, 1'b1, $random(seed));
        end

        for (int i = 0; i < 16; i++) begin
            a = $random(seed);
            saved.push_back(a);
            issue_instr(DMEM_SW, a, $random(seed), RES_ALU, 1'b1, $random(seed));
        end
        for (int i = 0; i < 16; i++)
            issue_instr(DMEM_LW, saved[i], '0, RES_MEM, 1'b1, i + 1);
        for (int i = 0; i < 16; i++) begin  // Store then load, back to back
            a = $random(seed);
            issue_instr(DMEM_SW, a, $random(seed), RES_ALU, 1'b1, $random(seed));
            issue_instr(DMEM_LW, a, '0, RES_MEM, 1'b1, $random(seed));
        end

        // Sub-word stores, word read back
        for (int r = 0; r < 4; r++) begin
            for (int off = 0; off < 4; off++) begin
                a = $random(seed);
                a[1:0] = off[1:0];
                issue_instr(DMEM_SB, a, $random(seed), RES_ALU, 1'b1, $random(seed));
                issue_instr(DMEM_LW, a, '0, RES_MEM, 1'b1, $random(seed));
                issue_instr(DMEM_SH, a, $random(seed), RES_ALU, 1'b1, $random(seed));
                issue_instr(DMEM_LW, a, '0, RES_MEM, 1'b1, $random(seed));
            end
        end

        // Sub-word loads, sign bit alternates per round
        for (int r = 0; r < 4; r++) begin
            for (int off = 0; off < 4; off++) begin
                for (int k = 0; k < 4; k++) begin
                    a = $random(seed);
                    a[1:0] = off[1:0];
                    d = $random(seed);
                    d[7] = r[0];
                    d[15] = r[0];
                    t = (k < 2) ? DMEM_SB : DMEM_SH;
                    issue_instr(t, a, d, RES_ALU, 1'b1, $random(seed));
                    issue_instr(ld_types[k], a, '0, RES_MEM, 1'b1, $random(seed));
                end
            end
        end

        for (int i = 0; i < N_SRC; i++) begin  // Non-memory sources, x0 mixed in
            case (i % 4)
                0:       s = RES_ALU;
                1:       s = RES_IMM;
                2:       s = RES_PC4;
                default: s = 4'hb;  // Unknown code
            endcase
            rd = (i % 8 < 2) ? '0 : $random(seed);
            issue_instr(DMEM_NO, $random(seed), $random(seed), s, 1'b1, rd);
        end

        for (int i = 0; i < N_RAND; i++) begin
            t = all_types[{$random(seed)} % 9];
            case ({$random(seed)} % 5)
                0:       s = RES_ALU;
                1:       s = RES_MEM;
                2:       s = RES_IMM;
                3:       s = RES_PC4;
                default: s = 4'he;
            endcase
            if (s == RES_MEM && (t == DMEM_NO || t == DMEM_SB || t == DMEM_SH || t == DMEM_SW))
                s = RES_ALU;  // Memory result only for loads
            issue_instr(t, $random(seed), $random(seed), s, $random(seed), $random(seed));
        end

        for (int i = 0; i < N_FLUSH; i++)
            issue_instr(DMEM_NO, '0, '0, RES_ALU, 1'b0, '0);
        while (exp_stamp_q.size() != 0)
            @(negedge clk);

        $display("TEST PASS");
        $finish;
    end

endmodule

//--- rv_mem.f
hdl/rv_mem_pkg.sv
hdl/store_align.sv
hdl/dmem_sram.sv
hdl/load_extract.sv
hdl/mem_stage.sv
hdl/wb_select.sv
hdl/rv_mem_top.sv
tb/rv_mem_tb.sv
